// File: source/lc3b_types.sv
package lc3b_types;

    // ======================================================================
    // basic scalar types
    // ======================================================================

    typedef logic [15:0] lc3b_word;      // data or byte address.
    typedef logic [1:0]  lc3b_mem_wmask; // bit 0 low byte, bit 1 high byte.
    typedef logic [8:0]  lc3b_c_tag;     // address bits 15:7.
    typedef logic [2:0]  lc3b_c_index;   // address bits 6:4.

    // one 128-bit line, word 0 in the low sixteen bits.
    typedef union packed {
        logic [127:0]       flat;
        lc3b_word [7:0]     words;
    } lc3b_cacheline;

    // ======================================================================
    // port bundles
    // ======================================================================

    typedef struct packed {
        logic          read;
        logic          write;
        lc3b_word      address;
        lc3b_word      wdata;
        lc3b_mem_wmask byte_enable;
    } l2_cpu_req_t;

    // write set means writeback, clear means fill.
    typedef struct packed {
        logic          write;
        lc3b_word      address;   // always line aligned.
        lc3b_cacheline wdata;
    } l2_mem_req_t;

    typedef struct packed {
        lc3b_cacheline rdata;
    } l2_mem_resp_t;

    // per-way load strobes and values from the FSM.
    typedef struct packed {
        logic load_d;
        logic load_v;
        logic load_td;
        logic d_in;
        logic v_in;
    } l2_way_ctrl_t;

endpackage : lc3b_types

// File: source/l2_way.sv
`timescale 1ns/1ps

module l2_way (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lc3b_types::l2_way_ctrl_t   ctrl,
    input  lc3b_types::lc3b_c_index    index,
    input  lc3b_types::lc3b_c_tag      tag_in,
    input  lc3b_types::lc3b_cacheline  data_in,
    output logic                       d_out,
    output logic                       v_out,
    output lc3b_types::lc3b_c_tag      tag_out,
    output lc3b_types::lc3b_cacheline  data_out
);

    logic [7:0]                valid;
    logic [7:0]                dirty;
    lc3b_types::lc3b_c_tag     tags  [8];
    lc3b_types::lc3b_cacheline lines [8];

    // status bits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (ctrl.load_v) begin
                valid[index] <= ctrl.v_in;
            end
            if (ctrl.load_d) begin
                dirty[index] <= ctrl.d_in;
            end
        end
    end

    // tag and line always move as a pair.
    always_ff @(posedge clk) begin
        if (ctrl.load_td) begin
            tags[index]  <= tag_in;
            lines[index] <= data_in;
        end
    end

    // read side is purely combinational.
    assign v_out    = valid[index];
    assign d_out    = dirty[index];
    assign tag_out  = tags[index];
    assign data_out = lines[index];

endmodule : l2_way

// File: source/l2_cache_writelogic.sv
`timescale 1ns/1ps

module l2_cache_writelogic (
    input  logic                         fill,
    input  lc3b_types::lc3b_cacheline    mem_rdata,
    input  lc3b_types::lc3b_cacheline    old_line,
    input  logic [2:0]                   word_sel,
    input  lc3b_types::lc3b_word         wdata,
    input  lc3b_types::lc3b_mem_wmask    byte_enable,
    output lc3b_types::lc3b_cacheline    line_out
);

    always_comb begin
        line_out = old_line;
        if (fill) begin
            line_out.flat = mem_rdata.flat; // whole line from memory.
        end else begin
            // merge only the enabled bytes of one word.
            if (byte_enable[0]) begin
                line_out.words[word_sel][7:0] = wdata[7:0];
            end
            if (byte_enable[1]) begin
                line_out.words[word_sel][15:8] = wdata[15:8];
            end
        end
    end

endmodule : l2_cache_writelogic

// File: source/l2_cache_datapath.sv
`timescale 1ns/1ps

module l2_cache_datapath (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lc3b_types::l2_cpu_req_t     cpu_req,
    input  lc3b_types::l2_way_ctrl_t    way_ctrl0,
    input  lc3b_types::l2_way_ctrl_t    way_ctrl1,
    input  logic                        load_lru,
    input  logic                        line_src,
    input  logic                        way_sel,
    input  logic [1:0]                  addr_sel,
    input  lc3b_types::lc3b_cacheline   mem_rdata_line,
    output logic                        hit0,
    output logic                        hit1,
    output logic                        lru_out,
    output logic                        d_out0,
    output logic                        d_out1,
    output lc3b_types::lc3b_word        mem_rdata,
    output lc3b_types::l2_mem_req_t     enq_req
);

    lc3b_types::lc3b_c_tag     addr_tag;
    lc3b_types::lc3b_c_index   addr_index;
    logic                      v_out0, v_out1;
    lc3b_types::lc3b_c_tag     tag0, tag1;
    lc3b_types::lc3b_cacheline line0, line1, sel_line, new_line;
    logic [7:0]                lru;

    assign addr_tag   = cpu_req.address[15:7];
    assign addr_index = cpu_req.address[6:4];

    // ======================================================================
    // storage
    // ======================================================================

    l2_way way0 (
        .clk, .rst_n, .ctrl(way_ctrl0), .index(addr_index), .tag_in(addr_tag),
        .data_in(new_line), .d_out(d_out0), .v_out(v_out0), .tag_out(tag0),
        .data_out(line0)
    );

    l2_way way1 (
        .clk, .rst_n, .ctrl(way_ctrl1), .index(addr_index), .tag_in(addr_tag),
        .data_in(new_line), .d_out(d_out1), .v_out(v_out1), .tag_out(tag1),
        .data_out(line1)
    );

    l2_cache_writelogic writelogic (
        .fill(line_src), .mem_rdata(mem_rdata_line), .old_line(sel_line),
        .word_sel(cpu_req.address[3:1]), .wdata(cpu_req.wdata),
        .byte_enable(cpu_req.byte_enable), .line_out(new_line)
    );

    // lru bit names the way to evict; the accessed way becomes MRU.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (load_lru) begin
            lru[addr_index] <= ~way_sel;
        end
    end

    assign lru_out = lru[addr_index];

    // ======================================================================
    // lookup and outputs
    // ======================================================================

    assign hit0 = v_out0 & (tag0 == addr_tag);
    assign hit1 = v_out1 & (tag1 == addr_tag);

    assign sel_line  = way_sel ? line1 : line0;
    assign mem_rdata = sel_line.words[cpu_req.address[3:1]];

    always_comb begin
        enq_req.wdata = sel_line;       // only meaningful for writeback.
        case (addr_sel)
            2'd1: begin
                enq_req.write   = 1'b1;
                enq_req.address = {tag0, addr_index, 4'h0};
            end
            2'd2: begin
                enq_req.write   = 1'b1;
                enq_req.address = {tag1, addr_index, 4'h0};
            end
            default: begin
                enq_req.write   = 1'b0; // fill of the cpu line.
                enq_req.address = {cpu_req.address[15:4], 4'h0};
            end
        endcase
    end

endmodule : l2_cache_datapath

// File: source/l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lc3b_types::l2_cpu_req_t     cpu_req,
    input  logic                        hit0,
    input  logic                        hit1,
    input  logic                        lru_out,
    input  logic                        d_out0,
    input  logic                        d_out1,
    input  logic                        mem_resp_valid,
    input  logic                        credit_return,
    output lc3b_types::l2_way_ctrl_t    way_ctrl0,
    output lc3b_types::l2_way_ctrl_t    way_ctrl1,
    output logic                        load_lru,
    output logic                        line_src,
    output logic                        way_sel,
    output logic [1:0]                  addr_sel,
    output logic                        enq_valid,
    output logic                        mem_resp
);

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] CHECK     = 3'd1;
    localparam logic [2:0] WB_REQ    = 3'd2;
    localparam logic [2:0] FILL_REQ  = 3'd3;
    localparam logic [2:0] FILL_WAIT = 3'd4;
    localparam logic [2:0] RESPOND   = 3'd5;

    logic [2:0]               state, next_state;
    logic [CREDIT_W-1:0]      credits;
    logic                     hit, victim, victim_dirty, have_credit;
    logic                     tgt_way;
    lc3b_types::l2_way_ctrl_t tgt_ctrl;

    assign hit          = hit0 | hit1;
    assign victim       = lru_out;   // LRU way is always the victim.
    assign victim_dirty = victim ? d_out1 : d_out0;
    assign have_credit  = (credits != '0);
    assign mem_resp     = (state == RESPOND);

    // ======================================================================
    // next state and outputs
    // ======================================================================

    always_comb begin
        next_state = state;
        tgt_way    = 1'b0;
        tgt_ctrl   = '0;
        load_lru   = 1'b0;
        line_src   = 1'b0;
        way_sel    = hit1;
        addr_sel   = 2'd0;
        enq_valid  = 1'b0;

        case (state)
            IDLE: begin
                if (cpu_req.read | cpu_req.write) begin
                    next_state = CHECK;
                end
            end
            CHECK: begin
                if (hit) begin
                    load_lru = 1'b1;
                    if (cpu_req.write) begin
                        // merged line goes back with the dirty bit set.
                        tgt_way          = hit1;
                        tgt_ctrl.load_td = 1'b1;
                        tgt_ctrl.load_d  = 1'b1;
                        tgt_ctrl.d_in    = 1'b1;
                    end
                    next_state = RESPOND;
                end else if (victim_dirty) begin
                    next_state = WB_REQ;
                end else begin
                    next_state = FILL_REQ;
                end
            end
            WB_REQ: begin
                way_sel  = victim;
                addr_sel = victim ? 2'd2 : 2'd1;
                if (have_credit) begin
                    enq_valid  = 1'b1;
                    next_state = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (have_credit) begin
                    enq_valid  = 1'b1;
                    next_state = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                line_src = 1'b1;
                if (mem_resp_valid) begin
                    tgt_way          = victim;
                    tgt_ctrl.load_td = 1'b1;
                    tgt_ctrl.load_v  = 1'b1;
                    tgt_ctrl.v_in    = 1'b1;
                    tgt_ctrl.load_d  = 1'b1; // fill is clean.
                    next_state       = CHECK;  // replay the access as a hit.
                end
            end
            RESPOND: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase

        way_ctrl0 = tgt_way ? '0 : tgt_ctrl;
        way_ctrl1 = tgt_way ? tgt_ctrl : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // producer credits: one per free queue slot.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(QUEUE_DEPTH);
        end else begin
            credits <= credits - CREDIT_W'(enq_valid) + CREDIT_W'(credit_return);
        end
    end

endmodule : l2_cache_control

// File: source/l2_mem_req_queue.sv
`timescale 1ns/1ps

module l2_mem_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     enq_valid,
    input  lc3b_types::l2_mem_req_t  enq_req,
    output logic                     credit_return,
    input  logic                     mem_credit,
    output logic                     mem_req_valid,
    output lc3b_types::l2_mem_req_t  mem_req
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    lc3b_types::l2_mem_req_t entries [QUEUE_DEPTH];
    logic [PTR_W-1:0]        head, tail;
    logic [CNT_W-1:0]        count;
    logic [CNT_W-1:0]        mem_credits;  // slots granted by memory.
    logic                    issue;

    // depth need not be a power of two.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign issue         = (count != '0) && (mem_credits != '0);
    assign mem_req_valid = issue;
    assign credit_return = issue;   // leaving entry frees an upstream slot.
    assign mem_req       = entries[head];

    always_ff @(posedge clk) begin
        if (enq_valid) begin
            entries[tail] <= enq_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            mem_credits <= '0;
        end else begin
            if (enq_valid) begin
                tail <= ptr_inc(tail);
            end
            if (issue) begin
                head <= ptr_inc(head);
            end
            count       <= count + CNT_W'(enq_valid) - CNT_W'(issue);
            mem_credits <= mem_credits + CNT_W'(mem_credit) - CNT_W'(issue);
        end
    end

endmodule : l2_mem_req_queue

// File: source/l2_cache_top.sv
`timescale 1ns/1ps

module l2_cache_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lc3b_types::l2_cpu_req_t     cpu_req,
    output lc3b_types::lc3b_word        mem_rdata,
    output logic                        mem_resp,
    input  logic                        mem_credit,
    output logic                        mem_req_valid,
    output lc3b_types::l2_mem_req_t     mem_req,
    input  logic                        mem_resp_valid,
    input  lc3b_types::l2_mem_resp_t    mem_resp_data
);

    lc3b_types::l2_way_ctrl_t way_ctrl0, way_ctrl1;
    logic                     load_lru, line_src, way_sel;
    logic [1:0]               addr_sel;
    logic                     hit0, hit1, lru_out, d_out0, d_out1;
    logic                     enq_valid, credit_return;
    lc3b_types::l2_mem_req_t  enq_req;

    // ======================================================================
    // cache FSM, datapath and memory request queue
    // ======================================================================

    l2_cache_control #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) control (
        .clk, .rst_n, .cpu_req,
        .hit0, .hit1, .lru_out, .d_out0, .d_out1,
        .mem_resp_valid, .credit_return,
        .way_ctrl0, .way_ctrl1, .load_lru, .line_src, .way_sel, .addr_sel,
        .enq_valid, .mem_resp
    );

    l2_cache_datapath datapath (
        .clk, .rst_n, .cpu_req,
        .way_ctrl0, .way_ctrl1, .load_lru, .line_src, .way_sel, .addr_sel,
        .mem_rdata_line(mem_resp_data.rdata),
        .hit0, .hit1, .lru_out, .d_out0, .d_out1,
        .mem_rdata, .enq_req
    );

    l2_mem_req_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) req_queue (
        .clk, .rst_n,
        .enq_valid, .enq_req, .credit_return,
        .mem_credit, .mem_req_valid, .mem_req
    );

endmodule : l2_cache_top

// File: test/l2_cache_checker.sv
`timescale 1ns/1ps

module l2_cache_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lc3b_types::l2_cpu_req_t   cpu_req,
    input  lc3b_types::lc3b_word      mem_rdata,
    input  logic                      mem_resp,
    input  logic                      mem_credit,
    input  logic                      mem_req_valid,
    input  lc3b_types::l2_mem_req_t   mem_req,
    output int                        errors,
    output int                        responses
);

    localparam int HIT_EDGES = 2;   // a hit answers two rising edges after it is taken.

    lc3b_types::lc3b_word    golden [32768];  // cpu view of memory by word address.
    lc3b_types::lc3b_c_tag   tag_m  [8][2];
    logic [7:0][1:0]         valid_m, dirty_m;
    logic [7:0]              lru_m;           // way to evict next.
    lc3b_types::l2_mem_req_t expect_q [$];
    lc3b_types::l2_cpu_req_t cur;
    logic                    busy;
    logic                    hit_exp;         // no memory traffic predicted.
    int                      credits_left;
    int                      edges;           // rising edges since the request was taken.
    int                      reset_edges;

    initial begin
        errors      = 0;
        responses   = 0;
        reset_edges = 0;
        for (int i = 0; i < 32768; i++) begin
            golden[i] = 16'(i) ^ 16'h5a5a;
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("ERR %s expected %0h actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        errors++;
    endtask

    function automatic lc3b_types::lc3b_cacheline golden_line(input lc3b_types::lc3b_word addr);
        lc3b_types::lc3b_cacheline line;
        for (int i = 0; i < 8; i++) begin
            line.words[i] = golden[{addr[15:4], 3'(i)}];
        end
        return line;
    endfunction

    // ======================================================================
    // tag model that predicts the memory traffic of one access
    // ======================================================================

    task automatic start_access();
        lc3b_types::lc3b_c_index s;
        lc3b_types::lc3b_c_tag   t;
        lc3b_types::l2_mem_req_t r;
        logic                    v;
        s = cur.address[6:4];
        t = cur.address[15:7];
        if (!(valid_m[s][0] && tag_m[s][0] == t) && !(valid_m[s][1] && tag_m[s][1] == t)) begin
            v = lru_m[s];
            if (valid_m[s][v] && dirty_m[s][v]) begin
                r.write   = 1'b1;
                r.address = {tag_m[s][v], s, 4'h0};
                r.wdata   = golden_line(r.address); // dirty line holds the cpu view.
                expect_q.push_back(r);
            end
            r.write   = 1'b0;
            r.address = {cur.address[15:4], 4'h0};
            r.wdata   = '0;
            expect_q.push_back(r);
            tag_m[s][v]   = t;
            valid_m[s][v] = 1'b1;
            dirty_m[s][v] = 1'b0;
        end
    endtask

    task automatic check_request();
        lc3b_types::l2_mem_req_t exp;
        if (expect_q.size() == 0) begin
            report_failure($sformatf("memory request to %h with no miss pending",
                                     mem_req.address));
        end else begin
            exp = expect_q.pop_front();
            if (mem_req.write !== exp.write) begin
                report_mismatch("req_kind", exp.write, mem_req.write);
            end else if (mem_req.address !== exp.address) begin
                report_mismatch("req_address", exp.address, mem_req.address);
            end else if (exp.write && mem_req.wdata.flat !== exp.wdata.flat) begin
                report_mismatch("wb_data", exp.wdata.flat, mem_req.wdata.flat);
            end
        end
    endtask

    task automatic finish_access();
        lc3b_types::lc3b_c_index s;
        logic [14:0]             widx;
        logic                    w;
        s    = cur.address[6:4];
        widx = cur.address[15:1];
        w    = valid_m[s][1] && (tag_m[s][1] == cur.address[15:7]);
        if (hit_exp && edges != HIT_EDGES) begin
            report_mismatch("hit_latency", HIT_EDGES, edges);
        end
        if (expect_q.size() != 0) begin
            report_failure($sformatf("access to %h ended with %0d memory requests never issued",
                                     cur.address, expect_q.size()));
            expect_q.delete();
        end
        if (cur.read && mem_rdata !== golden[widx]) begin
            report_mismatch("read_data", golden[widx], mem_rdata);
        end
        if (cur.write) begin
            if (cur.byte_enable[0]) begin
                golden[widx][7:0] = cur.wdata[7:0];
            end
            if (cur.byte_enable[1]) begin
                golden[widx][15:8] = cur.wdata[15:8];
            end
            dirty_m[s][w] = 1'b1;
        end
        lru_m[s] = ~w;
        responses++;
    endtask

    // ======================================================================
    // port monitor
    // ======================================================================

    always @(posedge clk) begin
        if (!rst_n) begin
            // outputs are unknown until the first reset edge.
            if (reset_edges != 0 && (mem_resp !== 1'b0 || mem_req_valid !== 1'b0)) begin
                report_failure("cache response or memory request not low during reset");
            end
            reset_edges++;
            valid_m      = '0;
            dirty_m      = '0;
            lru_m        = '0;
            busy         = 1'b0;
            credits_left = 0;
            expect_q.delete();
        end else begin
            if (mem_req_valid) begin
                if (credits_left == 0) begin
                    report_failure("memory request issued without a granted credit");
                end else begin
                    credits_left--;
                end
                check_request();
            end
            if (mem_credit) begin
                credits_left++;     // usable from the next cycle.
            end
            if (busy) begin
                edges++;
            end
            if (mem_resp) begin
                if (!busy) begin
                    report_failure("cache response with no request outstanding");
                end else begin
                    finish_access();
                end
                busy = 1'b0;
            end else if (!busy && (cpu_req.read || cpu_req.write)) begin
                cur   = cpu_req;
                busy  = 1'b1;
                edges = 0;
                start_access();
                hit_exp = (expect_q.size() == 0);
            end
        end
    end

endmodule : l2_cache_checker

// File: test/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

    localparam int QUEUE_DEPTH = 4;
    localparam int DIRECTED    = 11;
    localparam int RANDOM_REQS = 400;
    localparam int NUM_REQS    = DIRECTED + RANDOM_REQS;

    logic                     clk = 1'b0;
    logic                     rst_n;
    lc3b_types::l2_cpu_req_t  cpu_req;
    lc3b_types::lc3b_word     mem_rdata;
    logic                     mem_resp, mem_credit, mem_req_valid, mem_resp_valid;
    lc3b_types::l2_mem_req_t  mem_req;
    lc3b_types::l2_mem_resp_t mem_resp_data;

    integer                   seed = 32'h99cc1e9a;
    lc3b_types::lc3b_word     mem [32768];   // backing store, word addressed.
    lc3b_types::lc3b_word     fill_addr;
    int                       unused_credits, fill_delay, credit_odds;
    int                       errors, responses;

    always #2 clk = ~clk;

    l2_cache_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) uut (
        .clk, .rst_n, .cpu_req, .mem_rdata, .mem_resp,
        .mem_credit, .mem_req_valid, .mem_req, .mem_resp_valid, .mem_resp_data
    );

    l2_cache_checker chk (
        .clk, .rst_n, .cpu_req, .mem_rdata, .mem_resp,
        .mem_credit, .mem_req_valid, .mem_req, .errors, .responses
    );

    // ======================================================================
    // memory model
    // ======================================================================

    always @(negedge clk) begin
        mem_credit     = 1'b0;
        mem_resp_valid = 1'b0;
        if (!rst_n) begin
            unused_credits = 0;
            fill_delay     = 0;
        end else begin
            if (fill_delay != 0) begin
                fill_delay = fill_delay - 1;
                if (fill_delay == 0) begin
                    for (int i = 0; i < 8; i++) begin
                        mem_resp_data.rdata.words[i] = mem[{fill_addr[15:4], 3'(i)}];
                    end
                    mem_resp_valid = 1'b1;
                end
            end
            if (mem_req_valid) begin
                unused_credits = unused_credits - 1;
                if (mem_req.write) begin
                    for (int i = 0; i < 8; i++) begin
                        mem[{mem_req.address[15:4], 3'(i)}] = mem_req.wdata.words[i];
                    end
                end else begin
                    fill_addr  = mem_req.address;
                    fill_delay = 1 + $unsigned($random(seed)) % 6;
                end
            end
            if (unused_credits < QUEUE_DEPTH && $unsigned($random(seed)) % 16 < credit_odds) begin
                mem_credit     = 1'b1;
                unused_credits = unused_credits + 1;
            end
        end
    end

    // ======================================================================
    // cpu side
    // ======================================================================

    // holds the request until the one-cycle response, then returns on a falling edge.
    task automatic access(input logic write, input lc3b_types::lc3b_word addr,
                          input lc3b_types::lc3b_word wdata, input lc3b_types::lc3b_mem_wmask mask);
        cpu_req.read        = ~write;
        cpu_req.write       = write;
        cpu_req.address     = addr;
        cpu_req.wdata       = wdata;
        cpu_req.byte_enable = mask;
        do begin
            @(posedge clk);
        end while (!mem_resp);
        @(negedge clk);
    endtask

    function automatic lc3b_types::lc3b_word word_addr(input logic [8:0] tag,
                                                       input logic [2:0] set,
                                                       input logic [2:0] word);
        return {tag, set, word, 1'b0};
    endfunction

    task automatic random_access();
        logic [31:0] r;
        logic [31:0] d;
        logic [8:0]  tag;
        r   = $random(seed);
        d   = $random(seed);
        tag = (r[31:29] == 3'd0) ? r[28:20] : 9'(r[28:20] % 24);  // mostly 24 tags.
        access(r[13], word_addr(tag, r[19:17], r[16:14]), d[15:0],
               (r[12:11] == 2'b00) ? 2'b11 : r[12:11]);
    endtask

    initial begin
        cpu_req        = '0;
        rst_n          = 1'b0;
        mem_credit     = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        credit_odds    = 8;
        unused_credits = 0;
        fill_delay     = 0;
        for (int i = 0; i < 32768; i++) begin
            mem[i] = 16'(i) ^ 16'h5a5a;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // tags a, b, c share set 3.
        access(1'b0, word_addr(9'h011, 3'd3, 3'd2), 16'h0000, 2'b00);
        access(1'b1, word_addr(9'h011, 3'd3, 3'd2), 16'hbeef, 2'b01);
        access(1'b1, word_addr(9'h011, 3'd3, 3'd2), 16'hcafe, 2'b10);
        access(1'b0, word_addr(9'h011, 3'd3, 3'd2), 16'h0000, 2'b00);
        access(1'b0, word_addr(9'h022, 3'd3, 3'd0), 16'h0000, 2'b00);
        access(1'b0, word_addr(9'h011, 3'd3, 3'd5), 16'h0000, 2'b00);
        access(1'b0, word_addr(9'h033, 3'd3, 3'd1), 16'h0000, 2'b00); // evicts b.
        access(1'b1, word_addr(9'h033, 3'd3, 3'd1), 16'h1234, 2'b11);
        access(1'b0, word_addr(9'h022, 3'd3, 3'd0), 16'h0000, 2'b00); // dirty a goes out.
        access(1'b0, word_addr(9'h011, 3'd3, 3'd2), 16'h0000, 2'b00);
        access(1'b0, word_addr(9'h033, 3'd3, 3'd1), 16'h0000, 2'b00);

        for (int n = 0; n < RANDOM_REQS; n++) begin
            credit_odds = (n >= 150 && n < 230) ? 1 : 8;  // starve memory credits for a while.
            random_access();
        end
        cpu_req = '0;
        repeat (20) @(negedge clk);

        if (responses != NUM_REQS) begin
            $display("only %0d of %0d requests received a response", responses, NUM_REQS);
        end
        $display("requests: %0d  responses: %0d  errors: %0d", NUM_REQS, responses, errors);
        if (errors == 0 && responses == NUM_REQS) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_REQS * 200 + 1000) @(posedge clk);
        $display("watchdog expired before all requests completed");
        $display("Test failed");
        $finish;
    end

endmodule : l2_cache_tb

// File: files.f
source/lc3b_types.sv
source/l2_way.sv
source/l2_cache_writelogic.sv
source/l2_cache_datapath.sv
source/l2_cache_control.sv
source/l2_mem_req_queue.sv
source/l2_cache_top.sv
test/l2_cache_checker.sv
test/l2_cache_tb.sv
